// File: hw/z8Pkg.sv
package z8Pkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] busAddrT;
    typedef logic [7:0]  regAddrT;
    typedef logic [3:0]  nibbleT;

    // Flag byte as seen at register FC
    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic       d;
        logic       h;
        logic [1:0] user;
    } flagsT;

    // Two-operand ops, value is the high opcode nibble
    typedef enum logic [3:0] {
        opAdd = 4'h0,
        opAdc = 4'h1,
        opSub = 4'h2,
        opSbc = 4'h3,
        opOr  = 4'h4,
        opAnd = 4'h5,
        opTcm = 4'h6,
        opTm  = 4'h7,
        opCp  = 4'hA,
        opXor = 4'hB
    } aluOpT;

    // Low opcode nibbles with kept instructions
    typedef enum logic [3:0] {
        lowSrp     = 4'h1,
        lowRegPair = 4'h2,
        lowDjnz    = 4'hA,
        lowJr      = 4'hB,
        lowLdImm   = 4'hC,
        lowFlag    = 4'hF
    } lowNibT;

    // High nibble within the xF group
    typedef enum logic [3:0] {
        opRcf = 4'hC,
        opScf = 4'hD,
        opCcf = 4'hE
    } flagOpT;

    typedef enum logic [2:0] {
        fetch,
        fetch2,
        fetch3,
        decode,
        aluExec,
        djnzExec,
        storeAddr,
        store
    } seqStateT;

    typedef struct packed {
        busAddrT addr;
        byteT    wdata;
        logic    write;
    } busReqT;

    typedef struct packed {
        regAddrT srcA;
        regAddrT srcB;
        regAddrT dst;
        byteT    wdata;
        logic    we;
    } regReqT;

    localparam regAddrT flagsAddr   = 8'hFC;
    localparam regAddrT pointerAddr = 8'hFD;

    // High nibbles of srp (x1) and ldc Irr,r (x2)
    localparam nibbleT srpHigh = 4'h3;
    localparam nibbleT ldcHigh = 4'hD;

endpackage

// File: hw/z8Alu.sv
`timescale 1ns/100ps

module z8Alu import z8Pkg::*; (
    input  byteT  a,
    input  byteT  b,
    input  aluOpT op,
    input  flagsT flagsIn,
    output byteT  y,
    output flagsT flagsOut
);

    logic [8:0] sum;
    logic [8:0] diff;
    logic       carryIn;
    logic       addOvf;
    logic       subOvf;

    // Only adc and sbc take the carry
    assign carryIn = (op == opAdc || op == opSbc) ? flagsIn.c : 1'b0;

    assign sum  = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};
    assign diff = {1'b0, a} - {1'b0, b} - {8'h00, carryIn};

    // Same-sign inputs give a result of the other sign
    assign addOvf = (a[7] == b[7]) && (sum[7] != a[7]);
    assign subOvf = (a[7] != b[7]) && (diff[7] != a[7]);

    always_comb begin
        flagsOut = flagsIn;
        y = a;
        case (op)
            opAdd, opAdc: begin
                y = sum[7:0];
                flagsOut.c = sum[8];
                flagsOut.v = addOvf;
            end
            opSub, opSbc, opCp: begin
                y = diff[7:0];
                flagsOut.c = diff[8];
                flagsOut.v = subOvf;
            end
            opOr: begin
                y = a | b;
                flagsOut.v = 1'b0;
            end
            opAnd, opTm: begin
                y = a & b;
                flagsOut.v = 1'b0;
            end
            opTcm: begin
                y = ~a & b;
                flagsOut.v = 1'b0;
            end
            opXor: begin
                y = a ^ b;
                flagsOut.v = 1'b0;
            end
            default: begin
                y = a;
            end
        endcase
        flagsOut.z = (y == 8'h00);
        flagsOut.s = y[7];
        // No decimal adjust in this core
        flagsOut.d = 1'b0;
        flagsOut.h = 1'b0;
    end

endmodule

// File: hw/z8RegFile.sv
`timescale 1ns/100ps

module z8RegFile import z8Pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regReqT regReq,
    input  logic   flagsWe,
    input  flagsT  flagsNext,
    output byteT   rdA,
    output byteT   rdB,
    output nibbleT pointer,
    output flagsT  flags
);

    byteT regs [128];

    function automatic byteT readReg(regAddrT addr);
        if (!addr[7]) begin
            return regs[addr[6:0]];
        end
        case (addr)
            flagsAddr:   return flags;
            pointerAddr: return {pointer, 4'h0};
            default:     return 8'h00;
        endcase
    endfunction

    // D and H are held at zero
    function automatic flagsT cleanFlags(byteT value);
        return flagsT'({value[7:4], 2'b00, value[1:0]});
    endfunction

    assign rdA = readReg(regReq.srcA);
    assign rdB = readReg(regReq.srcB);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pointer <= 4'h0;
            flags   <= '0;
        end else begin
            if (regReq.we && regReq.dst == pointerAddr) begin
                pointer <= regReq.wdata[7:4];
            end
            // Explicit write to FC wins over the ALU flags
            if (regReq.we && regReq.dst == flagsAddr) begin
                flags <= cleanFlags(regReq.wdata);
            end else if (flagsWe) begin
                flags <= cleanFlags(flagsNext);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (regReq.we && !regReq.dst[7]) begin
            regs[regReq.dst[6:0]] <= regReq.wdata;
        end
    end

endmodule

// File: hw/z8BusPort.sv
`timescale 1ns/100ps

module z8BusPort import z8Pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   start,
    input  busReqT xfer,
    output logic   done,
    output byteT   rdByte,
    output busReqT busReq,
    output logic   req,
    input  logic   ack,
    input  byteT   rdata
);

    // Waiting for ack to fall before the next req
    logic ackWait;
    // Start seen while ack was still high
    logic pending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            req     <= 1'b0;
            done    <= 1'b0;
            ackWait <= 1'b1;
            pending <= 1'b0;
        end else begin
            done <= 1'b0;
            if (req) begin
                if (ack) begin
                    req     <= 1'b0;
                    done    <= 1'b1;
                    ackWait <= 1'b1;
                end
            end else if (ackWait) begin
                if (!ack) begin
                    ackWait <= 1'b0;
                    req     <= pending || start;
                    pending <= 1'b0;
                end else if (start) begin
                    pending <= 1'b1;
                end
            end else if (start) begin
                req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            busReq <= xfer;
        end
        if (req && ack) begin
            rdByte <= rdata;
        end
    end

endmodule

// File: hw/z8Sequencer.sv
`timescale 1ns/100ps

module z8Sequencer import z8Pkg::*; #(
    parameter busAddrT resetPc = 16'h000C
) (
    input  logic   clk,
    input  logic   rstN,
    output logic   start,
    output busReqT xfer,
    input  logic   done,
    input  byteT   rdByte,
    output regReqT regReq,
    input  byteT   rdA,
    input  byteT   rdB,
    input  nibbleT pointer,
    input  flagsT  flags,
    output aluOpT  aluOp,
    input  byteT   aluY,
    input  flagsT  aluFlags,
    output logic   flagsWe,
    output flagsT  flagsNext
);

    seqStateT state;
    busAddrT  pc;
    busAddrT  dataAddr;
    byteT     opcode;
    byteT     second;
    logic     waiting;
    nibbleT   opHigh;
    nibbleT   opLow;
    nibbleT   secHigh;
    nibbleT   secLow;
    logic     isAluOp;
    logic     aluWrites;
    logic     condTrue;
    logic     takeJr;
    byteT     djnzY;
    busAddrT  relTarget;

    function automatic regAddrT workReg(nibbleT n);
        return {pointer, n};
    endfunction

    function automatic logic oneByte(nibbleT low);
        return low[3:1] == 3'b111;
    endfunction

    function automatic logic threeByte(nibbleT low);
        return low[3:2] == 2'b01 || low == 4'hD;
    endfunction

    assign opHigh  = opcode[7:4];
    assign opLow   = opcode[3:0];
    assign secHigh = second[7:4];
    assign secLow  = second[3:0];

    assign aluOp     = aluOpT'(opHigh);
    assign isAluOp   = opHigh inside {[4'h0:4'h7], 4'hA, 4'hB};
    assign aluWrites = !(aluOp inside {opCp, opTcm, opTm});
    // Decrement done locally, flags are not touched
    assign djnzY     = rdA - 8'd1;
    assign relTarget = pc + {{8{second[7]}}, second};

    always_comb begin
        case (opHigh[2:0])
            3'd0:    condTrue = 1'b0;
            3'd1:    condTrue = flags.s ^ flags.v;
            3'd2:    condTrue = (flags.s ^ flags.v) | flags.z;
            3'd3:    condTrue = flags.c | flags.z;
            3'd4:    condTrue = flags.v;
            3'd5:    condTrue = flags.s;
            3'd6:    condTrue = flags.z;
            default: condTrue = flags.c;
        endcase
    end

    // Upper half of the table is the inverse
    assign takeJr = condTrue ^ opHigh[3];

    always_comb begin
        start        = 1'b0;
        xfer.addr    = pc;
        xfer.wdata   = 8'h00;
        xfer.write   = 1'b0;
        regReq.srcA  = workReg(secHigh);
        regReq.srcB  = workReg(secLow);
        regReq.dst   = workReg(secHigh);
        regReq.wdata = aluY;
        regReq.we    = 1'b0;
        flagsWe      = 1'b0;
        flagsNext    = aluFlags;
        case (state)
            fetch, fetch2, fetch3: begin
                start = !waiting;
            end
            decode: begin
                case (opLow)
                    lowLdImm: begin
                        regReq.dst   = workReg(opHigh);
                        regReq.wdata = second;
                        regReq.we    = 1'b1;
                    end
                    lowSrp: begin
                        regReq.dst   = pointerAddr;
                        regReq.wdata = second;
                        regReq.we    = (opHigh == srpHigh);
                    end
                    lowFlag: begin
                        flagsNext = flags;
                        case (opHigh)
                            opRcf: begin
                                flagsNext.c = 1'b0;
                                flagsWe     = 1'b1;
                            end
                            opScf: begin
                                flagsNext.c = 1'b1;
                                flagsWe     = 1'b1;
                            end
                            opCcf: begin
                                flagsNext.c = ~flags.c;
                                flagsWe     = 1'b1;
                            end
                            default: begin
                            end
                        endcase
                    end
                    default: begin
                    end
                endcase
            end
            aluExec: begin
                regReq.we = aluWrites;
                flagsWe   = 1'b1;
            end
            djnzExec: begin
                regReq.srcA  = workReg(opHigh);
                regReq.dst   = workReg(opHigh);
                regReq.wdata = djnzY;
                regReq.we    = 1'b1;
            end
            storeAddr: begin
                // Even register is the high address byte
                regReq.srcA = workReg({secLow[3:1], 1'b0});
                regReq.srcB = workReg({secLow[3:1], 1'b1});
            end
            store: begin
                start      = !waiting;
                xfer.addr  = dataAddr;
                xfer.wdata = rdA;
                xfer.write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= fetch;
            pc      <= resetPc;
            waiting <= 1'b0;
        end else begin
            if (start) begin
                waiting <= 1'b1;
            end
            if (done) begin
                waiting <= 1'b0;
            end
            case (state)
                fetch: begin
                    if (done) begin
                        pc    <= pc + 16'd1;
                        state <= oneByte(rdByte[3:0]) ? decode : fetch2;
                    end
                end
                fetch2: begin
                    if (done) begin
                        pc    <= pc + 16'd1;
                        state <= threeByte(opLow) ? fetch3 : decode;
                    end
                end
                fetch3: begin
                    // No kept opcode uses the third byte
                    if (done) begin
                        pc    <= pc + 16'd1;
                        state <= decode;
                    end
                end
                decode: begin
                    state <= fetch;
                    case (opLow)
                        lowRegPair: begin
                            if (isAluOp) begin
                                state <= aluExec;
                            end else if (opHigh == ldcHigh) begin
                                state <= storeAddr;
                            end
                        end
                        lowDjnz: begin
                            state <= djnzExec;
                        end
                        lowJr: begin
                            if (takeJr) begin
                                pc <= relTarget;
                            end
                        end
                        default: begin
                        end
                    endcase
                end
                djnzExec: begin
                    if (djnzY != 8'h00) begin
                        pc <= relTarget;
                    end
                    state <= fetch;
                end
                storeAddr: begin
                    state <= store;
                end
                store: begin
                    if (done) begin
                        state <= fetch;
                    end
                end
                default: begin
                    state <= fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (done && state == fetch) begin
            opcode <= rdByte;
        end
        if (done && state == fetch2) begin
            second <= rdByte;
        end
        if (state == storeAddr) begin
            dataAddr <= {rdA, rdB};
        end
    end

endmodule

// File: hw/z8Core.sv
`timescale 1ns/100ps

module z8Core import z8Pkg::*; #(
    parameter busAddrT resetPc = 16'h000C
) (
    input  logic   clk,
    input  logic   rstN,
    output busReqT busReq,
    output logic   req,
    input  logic   ack,
    input  byteT   rdata
);

    logic   start;
    busReqT xfer;
    logic   done;
    byteT   rdByte;
    regReqT regReq;
    byteT   rdA;
    byteT   rdB;
    nibbleT pointer;
    flagsT  flags;
    aluOpT  aluOp;
    byteT   aluY;
    flagsT  aluFlags;
    logic   flagsWe;
    flagsT  flagsNext;

    z8Sequencer #(
        .resetPc(resetPc)
    ) sequencer (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .xfer     (xfer),
        .done     (done),
        .rdByte   (rdByte),
        .regReq   (regReq),
        .rdA      (rdA),
        .rdB      (rdB),
        .pointer  (pointer),
        .flags    (flags),
        .aluOp    (aluOp),
        .aluY     (aluY),
        .aluFlags (aluFlags),
        .flagsWe  (flagsWe),
        .flagsNext(flagsNext)
    );

    z8RegFile regFile (
        .clk      (clk),
        .rstN     (rstN),
        .regReq   (regReq),
        .flagsWe  (flagsWe),
        .flagsNext(flagsNext),
        .rdA      (rdA),
        .rdB      (rdB),
        .pointer  (pointer),
        .flags    (flags)
    );

    // Operands come straight from the two read ports
    z8Alu alu (
        .a       (rdA),
        .b       (rdB),
        .op      (aluOp),
        .flagsIn (flags),
        .y       (aluY),
        .flagsOut(aluFlags)
    );

    z8BusPort busPort (
        .clk   (clk),
        .rstN  (rstN),
        .start (start),
        .xfer  (xfer),
        .done  (done),
        .rdByte(rdByte),
        .busReq(busReq),
        .req   (req),
        .ack   (ack),
        .rdata (rdata)
    );

endmodule

// File: test/z8TbTasks.svh
`ifndef Z8_TB_TASKS_SVH
`define Z8_TB_TASKS_SVH

// 17-bit Fibonacci LFSR with taps 17 and 14
function automatic logic [31:0] randBits(int n);
    logic [31:0] value;
    logic        bitOut;
    value = '0;
    for (int i = 0; i < n; i++) begin
        bitOut = lfsrState[16] ^ lfsrState[13];
        lfsrState = {lfsrState[15:0], bitOut};
        value = {value[30:0], bitOut};
    end
    return value;
endfunction

task automatic checkByte(string name, byteT got, byteT exp);
    if (got !== exp) begin
        stopOnError($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
endtask

task automatic checkAddr(string name, busAddrT got, busAddrT exp);
    if (got !== exp) begin
        stopOnError($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
endtask

task automatic checkFlags(string name, flagsT got, flagsT exp);
    if (got !== exp) begin
        stopOnError($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
endtask

// Reference ALU over signed and unsigned integer ranges
task automatic aluModel(input aluOpT op, input byteT a, input byteT b, input flagsT fin,
                        output byteT y, output flagsT f);
    int ua;
    int ub;
    int sa;
    int sb;
    int cin;
    f = fin;
    ua = int'(a);
    ub = int'(b);
    sa = int'($signed(a));
    sb = int'($signed(b));
    cin = (op == opAdc || op == opSbc) ? int'(fin.c) : 0;
    y = a;
    case (op)
        opAdd, opAdc: begin
            y = byteT'(ua + ub + cin);
            f.c = (ua + ub + cin) > 255;
            f.v = (sa + sb + cin) > 127 || (sa + sb + cin) < -128;
        end
        opSub, opSbc, opCp: begin
            y = byteT'(ua - ub - cin);
            f.c = (ua - ub - cin) < 0;
            f.v = (sa - sb - cin) > 127 || (sa - sb - cin) < -128;
        end
        opOr: y = a | b;
        opAnd, opTm: y = a & b;
        opTcm: y = ~a & b;
        default: y = a ^ b;
    endcase
    if (!(op inside {opAdd, opAdc, opSub, opSbc, opCp})) begin
        f.v = 1'b0;
    end
    f.z = (y == 8'h00);
    f.s = y[7];
    f.d = 1'b0;
    f.h = 1'b0;
endtask

function automatic logic condHolds(nibbleT cc, flagsT f);
    logic t;
    case (cc[2:0])
        3'd0: t = 1'b0;
        3'd1: t = f.s != f.v;
        3'd2: t = (f.s != f.v) || f.z;
        3'd3: t = f.c || f.z;
        3'd4: t = f.v;
        3'd5: t = f.s;
        3'd6: t = f.z;
        default: t = f.c;
    endcase
    return cc[3] ? !t : t;
endfunction

task automatic emit(byteT b);
    prog.push_back(b);
endtask

task automatic emitLd(nibbleT r, byteT imm);
    emit({r, 4'hC});
    emit(imm);
endtask

task automatic emitAlu(aluOpT op, nibbleT dst, nibbleT src);
    emit({op, 4'h2});
    emit({dst, src});
endtask

task automatic emitSrp(byteT v);
    emit(8'h31);
    emit(v);
endtask

task automatic emitLdc(nibbleT src, nibbleT pair);
    emit(8'hD2);
    emit({src, pair});
endtask

// Store to FFxx ends the program
task automatic emitHalt(byteT marker);
    emitSrp(8'h00);
    emitLd(4'hE, 8'hFF);
    emitLd(4'hF, marker);
    emitLdc(4'hF, 4'hE);
endtask

task automatic runProgram();
    @(negedge clk);
    rstN = 1'b0;
    halted = 1'b0;
    for (int i = 0; i < 65536; i++) begin
        mem[i] = byteT'(i[7:0] ^ i[15:8]);
    end
    foreach (prog[i]) begin
        mem[16'h000C + i] = prog[i];
    end
    prog.delete();
    wrAddr.delete();
    wrData.delete();
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    wait (halted);
    @(negedge clk);
endtask

task automatic expectStore(int idx, busAddrT addr, byteT data);
    if (idx >= wrAddr.size()) begin
        stopOnError($sformatf("Store number %0d never happened", idx));
    end
    checkAddr("busReq.addr", wrAddr[idx], addr);
    checkByte("busReq.wdata", wrData[idx], data);
endtask

task automatic testStores();
    busAddrT addrs [3];
    byteT    vals [3];
    for (int k = 0; k < 3; k++) begin
        addrs[k] = {4'h2, 4'(randBits(4)), 8'(randBits(8))};
        vals[k] = byteT'(randBits(8));
        emitLd(4'h4, addrs[k][15:8]);
        emitLd(4'h5, addrs[k][7:0]);
        emitLd(4'h6, vals[k]);
        emitLdc(4'h6, 4'h4);
    end
    emitHalt(8'h01);
    runProgram();
    for (int k = 0; k < 3; k++) begin
        expectStore(k, addrs[k], vals[k]);
    end
    expectStore(3, 16'hFF01, 8'h01);
endtask

task automatic testAluOps();
    aluOpT ops [10];
    byteT  a;
    byteT  b;
    byteT  y;
    flagsT fin;
    flagsT fexp;
    ops = '{opAdd, opAdc, opSub, opSbc, opOr, opAnd, opTcm, opTm, opCp, opXor};
    foreach (ops[i]) begin
        a = byteT'(randBits(8));
        b = byteT'(randBits(8));
        fin = '0;
        fin.c = randBits(1) != 0;
        emitLd(4'h1, a);
        emitLd(4'h2, b);
        emitLd(4'h4, 8'h00);
        emitLd(4'h5, 8'h01);
        if (fin.c) begin
            emit(8'hDF);
        end
        emitAlu(ops[i], 4'h1, 4'h2);
        // r12 is the flags register with the pointer at F
        emitSrp(8'hF0);
        emitLdc(4'hC, 4'hE);
        emitSrp(8'h00);
        emitLdc(4'h1, 4'h4);
        emitHalt(8'h10);
        runProgram();
        aluModel(ops[i], a, b, fin, y, fexp);
        if (wrData.size() < 3) begin
            stopOnError("ALU program made too few stores");
        end
        checkAddr("busReq.addr", wrAddr[0], 16'h0000);
        checkFlags("flags", flagsT'(wrData[0]), fexp);
        expectStore(1, 16'h0001, (ops[i] inside {opCp, opTm, opTcm}) ? a : y);
        expectStore(2, 16'hFF10, 8'h10);
    end
endtask

task automatic testFlagOps();
    byteT  y;
    flagsT f;
    byteT  flagOps [4];
    flagOps = '{8'hCF, 8'hDF, 8'hEF, 8'hEF};
    emitLd(4'h1, 8'h80);
    emitLd(4'h2, 8'h80);
    emitAlu(opAdd, 4'h1, 4'h2);
    emitSrp(8'hF0);
    foreach (flagOps[i]) begin
        emit(flagOps[i]);
        emitLdc(4'hC, 4'hE);
    end
    emitHalt(8'h20);
    runProgram();
    if (wrData.size() < 5) begin
        stopOnError("Flag program made too few stores");
    end
    aluModel(opAdd, 8'h80, 8'h80, flagsT'(8'h00), y, f);
    foreach (flagOps[i]) begin
        case (flagOps[i])
            8'hCF: f.c = 1'b0;
            8'hDF: f.c = 1'b1;
            default: f.c = !f.c;
        endcase
        checkAddr("busReq.addr", wrAddr[i], 16'h0000);
        checkFlags("flags", flagsT'(wrData[i]), f);
    end
    expectStore(4, 16'hFF20, 8'h20);
endtask

task automatic testDjnzLoop();
    byteT n;
    n = byteT'(randBits(4)) + 8'd1;
    emitLd(4'h1, n);
    emitLd(4'h2, 8'h00);
    emitLd(4'h3, 8'h01);
    emitLd(4'h4, 8'h00);
    emitLd(4'h5, 8'h02);
    emitAlu(opAdd, 4'h2, 4'h3);
    // Back over the add and the djnz itself
    emit(8'h1A);
    emit(8'hFC);
    emitLdc(4'h2, 4'h4);
    emitHalt(8'h30);
    runProgram();
    expectStore(0, 16'h0002, n);
    expectStore(1, 16'hFF30, 8'h30);
endtask

task automatic testJrConditions();
    byteT  a;
    byteT  b;
    byteT  y;
    flagsT f;
    for (int cc = 0; cc < 16; cc++) begin
        a = byteT'(randBits(8));
        b = byteT'(randBits(8));
        emitLd(4'h4, 8'h00);
        emitLd(4'h5, 8'h03);
        emitLd(4'h1, a);
        emitLd(4'h2, b);
        emitAlu(opCp, 4'h1, 4'h2);
        emit({4'(cc), 4'hB});
        emit(8'h04);
        emitLd(4'h6, 8'h55);
        emit(8'h8B);
        emit(8'h02);
        emitLd(4'h6, 8'hAA);
        emitLdc(4'h6, 4'h4);
        emitHalt(8'h40);
        runProgram();
        aluModel(opCp, a, b, flagsT'(8'h00), y, f);
        expectStore(0, 16'h0003, condHolds(4'(cc), f) ? 8'hAA : 8'h55);
        expectStore(1, 16'hFF40, 8'h40);
    end
endtask

task automatic testPointerBanks();
    byteT v1;
    byteT v2;
    v1 = byteT'(randBits(8));
    v2 = ~v1;
    emitSrp(8'h20);
    emitLd(4'h3, v1);
    emitSrp(8'h30);
    emitLd(4'h3, v2);
    emitSrp(8'h20);
    emitLd(4'h4, 8'h00);
    emitLd(4'h5, 8'h10);
    emitLdc(4'h3, 4'h4);
    emitSrp(8'h30);
    emitLd(4'h4, 8'h00);
    emitLd(4'h5, 8'h11);
    emitLdc(4'h3, 4'h4);
    emitHalt(8'h50);
    runProgram();
    expectStore(0, 16'h0010, v1);
    expectStore(1, 16'h0011, v2);
    expectStore(2, 16'hFF50, 8'h50);
endtask

`endif

// File: test/z8Tb.sv
`timescale 1ns/100ps

module z8Tb import z8Pkg::*; ();

    localparam int clkPeriod = 4;
    localparam int maxDelay = 7;
    localparam int instrBudget = 700;
    // Four bounded accesses per instruction at most
    localparam longint timeoutNs =
        longint'(instrBudget) * 4 * (maxDelay + 6) * clkPeriod * 3;

    logic   clk;
    logic   rstN;
    busReqT busReq;
    logic   req;
    logic   ack;
    byteT   rdata;

    byteT    mem [65536];
    byteT    prog [$];
    busAddrT wrAddr [$];
    byteT    wrData [$];
    logic    halted;
    logic    armed;
    int      delay;
    logic [16:0] lfsrState;

    z8Core #(
        .resetPc(16'h000C)
    ) UUT (
        .clk   (clk),
        .rstN  (rstN),
        .busReq(busReq),
        .req   (req),
        .ack   (ack),
        .rdata (rdata)
    );

    task automatic stopOnError(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "z8TbTasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // Memory model answering on the falling edge
    always @(negedge clk) begin
        if (!rstN) begin
            ack = 1'b0;
            armed = 1'b0;
            delay = 0;
        end else if (req && !ack) begin
            if (!armed) begin
                armed = 1'b1;
                delay = int'(randBits(3));
            end
            if (delay == 0) begin
                armed = 1'b0;
                if (busReq.write) begin
                    mem[busReq.addr] = busReq.wdata;
                    wrAddr.push_back(busReq.addr);
                    wrData.push_back(busReq.wdata);
                    if (busReq.addr[15:8] == 8'hFF) begin
                        halted = 1'b1;
                    end
                end else begin
                    rdata = mem[busReq.addr];
                end
                ack = 1'b1;
            end else begin
                delay--;
            end
        end else if (ack && !req) begin
            ack = 1'b0;
        end
    end

    initial begin
        #(timeoutNs);
        stopOnError("Watchdog expired before the tests finished");
    end

    initial begin
        rstN = 1'b0;
        ack = 1'b0;
        rdata = 8'h00;
        halted = 1'b0;
        armed = 1'b0;
        delay = 0;
        lfsrState = 17'd66264;
        testStores();
        testAluOps();
        testFlagOps();
        testDjnzLoop();
        testJrConditions();
        testPointerBanks();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: project.f
+incdir+test
hw/z8Pkg.sv
hw/z8Alu.sv
hw/z8RegFile.sv
hw/z8BusPort.sv
hw/z8Sequencer.sv
hw/z8Core.sv
test/z8Tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module z8Tb -o z8Sim &&
./obj_dir/z8Sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }
